// File: proc.f
source/procPkg.sv
source/pipeIfs.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memoryStage.sv
source/proc.sv
verif/proc_props.sv
verif/procTb.sv

// File: source/decode.sv
`timescale 1ns/1ps

module decode import procPkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  word_t   instr,
   input  word_t   pcPlusOne,
   input  logic    inValid,
   input  logic    flush,
   input  logic    wbEn,
   input  regIdx_t wbReg,
   input  word_t   wbData,
   input  regIdx_t exDest,
   input  logic    exWrites,
   output logic    stall,
   output logic    stopFetch,
   decExIf.src     toEx
);

   opcode_t opcode;
   regIdx_t rs;
   regIdx_t rt;
   regIdx_t rd;
   word_t   imm5;
   word_t   disp8;
   word_t   disp11;
   aluOp_t  aluOp;
   word_t   immediate;
   regIdx_t dest;
   logic    readsRs;
   logic    readsRt;
   logic    isStop;
   word_t   regs [REG_COUNT];
   word_t   rsData;
   word_t   rtData;
   regIdx_t memDest;
   logic    memWrites;
   logic    accept;
   logic    hazard;
   logic    stopped;

   assign opcode = opcode_t'(instr[OPC_MSB:OPC_LSB]);
   assign rs     = instr[RS_MSB:RS_LSB];
   assign rt     = instr[RT_MSB:RT_LSB];
   assign rd     = instr[RD_MSB:RD_LSB];
   assign imm5   = {{(WORD_W-IMM5_MSB-1){instr[IMM5_MSB]}}, instr[IMM5_MSB:0]};
   assign disp8  = {{(WORD_W-DISP8_MSB-1){instr[DISP8_MSB]}}, instr[DISP8_MSB:0]};
   assign disp11 = {{(WORD_W-DISP11_MSB-1){instr[DISP11_MSB]}}, instr[DISP11_MSB:0]};

   always_comb begin
      aluOp     = ALU_PASSB;
      immediate = '0;
      dest      = rt;
      readsRs   = 1'b0;
      readsRt   = 1'b0;
      isStop    = 1'b0;
      case (opcode)
         OP_NOP:  aluOp = ALU_PASSB;
         OP_HALT: isStop = 1'b1;
         OP_ADDI, OP_LD: begin
            aluOp     = ALU_ADD;
            immediate = imm5;
            readsRs   = 1'b1;
         end
         OP_ST: begin
            aluOp     = ALU_ADD;
            immediate = imm5;
            readsRs   = 1'b1;
            readsRt   = 1'b1;
         end
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            aluOp   = (opcode == OP_ADD) ? ALU_ADD :
                      (opcode == OP_SUB) ? ALU_SUB :
                      (opcode == OP_AND) ? ALU_AND : ALU_XOR;
            dest    = rd;
            readsRs = 1'b1;
            readsRt = 1'b1;
         end
         OP_BEQZ, OP_BNEZ: begin
            aluOp     = ALU_ZEROTEST;
            immediate = disp8;
            readsRs   = 1'b1;
         end
         OP_J:    immediate = disp11;
         // Illegal opcode stops the machine like HALT
         default: isStop = 1'b1;
      endcase
   end

   // Register file written from write-back
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wbEn) begin
         regs[wbReg] <= wbData;
      end
   end

   // Write-through covers a producer that is in write-back this cycle
   assign rsData = (wbEn && wbReg == rs) ? wbData : regs[rs];
   assign rtData = (wbEn && wbReg == rt) ? wbData : regs[rt];

   // Execute never stalls, so last cycle's execute writer is in memory now
   always_ff @(posedge clk) begin
      if (reset) begin
         memWrites <= 1'b0;
      end else begin
         memWrites <= exWrites;
      end
      memDest <= exDest;
   end

   assign hazard = (readsRs && ((exWrites && exDest == rs) || (memWrites && memDest == rs))) ||
                   (readsRt && ((exWrites && exDest == rt) || (memWrites && memDest == rt)));

   assign accept    = inValid && !flush;
   assign stall     = accept && hazard;
   assign stopFetch = stopped || (accept && isStop);

   always_ff @(posedge clk) begin
      if (reset) begin
         stopped    <= 1'b0;
         toEx.valid <= 1'b0;
      end else begin
         stopped    <= stopped || (accept && isStop);
         toEx.valid <= accept && !hazard;
      end
   end

   // A raw illegal opcode travels on so execute can flag it
   always_ff @(posedge clk) begin
      toEx.opcode    <= opcode;
      toEx.aluOp     <= aluOp;
      toEx.rsData    <= rsData;
      toEx.rtData    <= rtData;
      toEx.immediate <= immediate;
      toEx.pcPlusOne <= pcPlusOne;
      toEx.dest      <= dest;
   end

endmodule

// File: source/execute.sv
`timescale 1ns/1ps

module execute import procPkg::*; (
   input  logic    clk,
   input  logic    reset,
   decExIf.dst     fromDec,
   exMemIf.src     toMem,
   output logic    redirect,
   output word_t   target,
   output regIdx_t exDest,
   output logic    exWrites,
   output logic    haltOut,
   output logic    errOut
);

   word_t operandB;
   word_t aluResult;
   logic  useImm;
   logic  regWrite;
   logic  memRead;
   logic  memWrite;
   logic  isHalt;
   logic  isIllegal;
   logic  taken;

   always_comb begin
      useImm    = 1'b0;
      regWrite  = 1'b0;
      memRead   = 1'b0;
      memWrite  = 1'b0;
      isHalt    = 1'b0;
      isIllegal = 1'b0;
      case (fromDec.opcode)
         OP_ADDI: begin
            useImm   = 1'b1;
            regWrite = 1'b1;
         end
         OP_ADD, OP_SUB, OP_AND, OP_XOR: regWrite = 1'b1;
         OP_LD: begin
            useImm   = 1'b1;
            regWrite = 1'b1;
            memRead  = 1'b1;
         end
         OP_ST: begin
            useImm   = 1'b1;
            memWrite = 1'b1;
         end
         OP_HALT: isHalt = 1'b1;
         OP_NOP, OP_BEQZ, OP_BNEZ, OP_J: useImm = 1'b0;
         default: isIllegal = 1'b1;
      endcase
   end

   assign operandB = useImm ? fromDec.immediate : fromDec.rtData;

   always_comb begin
      case (fromDec.aluOp)
         ALU_ADD:      aluResult = fromDec.rsData + operandB;
         ALU_SUB:      aluResult = fromDec.rsData - operandB;
         ALU_AND:      aluResult = fromDec.rsData & operandB;
         ALU_XOR:      aluResult = fromDec.rsData ^ operandB;
         ALU_PASSB:    aluResult = operandB;
         ALU_ZEROTEST: aluResult = {{(WORD_W-1){1'b0}}, fromDec.rsData == '0};
         default:      aluResult = '0;
      endcase
   end

   // Branch on the zero flag from the ALU
   always_comb begin
      case (fromDec.opcode)
         OP_BEQZ: taken = aluResult[0];
         OP_BNEZ: taken = !aluResult[0];
         OP_J:    taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign redirect = fromDec.valid && taken;
   assign target   = fromDec.pcPlusOne + fromDec.immediate;
   assign exDest   = fromDec.dest;
   assign exWrites = fromDec.valid && regWrite;

   always_ff @(posedge clk) begin
      if (reset) begin
         toMem.valid    <= 1'b0;
         toMem.regWrite <= 1'b0;
         toMem.memRead  <= 1'b0;
         toMem.memWrite <= 1'b0;
         haltOut        <= 1'b0;
         errOut         <= 1'b0;
      end else begin
         toMem.valid    <= fromDec.valid;
         toMem.regWrite <= fromDec.valid && regWrite;
         toMem.memRead  <= fromDec.valid && memRead;
         toMem.memWrite <= fromDec.valid && memWrite;
         haltOut        <= fromDec.valid && (isHalt || isIllegal);
         errOut         <= fromDec.valid && isIllegal;
      end
   end

   always_ff @(posedge clk) begin
      toMem.result    <= aluResult;
      toMem.storeData <= fromDec.rtData;
      toMem.dest      <= fromDec.dest;
   end

endmodule

// File: source/fetch.sv
`timescale 1ns/1ps

module fetch import procPkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  stall,
   input  logic  stopFetch,
   input  logic  redirect,
   input  word_t target,
   output word_t instr,
   output word_t pcPlusOne,
   output logic  valid
);

   word_t pc;
   word_t rom [IMEM_WORDS];
   word_t romData;

   // Words past the end of the program read as NOP
   initial begin
      for (int i = 0; i < IMEM_WORDS; i++) begin
         rom[i] = '0;
      end
      $readmemh("verif/program.hex", rom);
   end

   assign romData = rom[pc[IMEM_AW-1:0]];

   // Redirect wins over stop and stall since the branch is older than anything in decode
   always_ff @(posedge clk) begin
      if (reset) begin
         pc    <= RESET_PC;
         valid <= 1'b0;
      end else if (redirect) begin
         pc    <= target;
         valid <= 1'b0;
      end else if (stopFetch) begin
         valid <= 1'b0;
      end else if (!stall) begin
         pc    <= pc + 1'b1;
         valid <= 1'b1;
      end
   end

   // Held while decode is stalled
   always_ff @(posedge clk) begin
      if (!stall) begin
         instr     <= romData;
         pcPlusOne <= pc + 1'b1;
      end
   end

endmodule

// File: source/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import procPkg::*; (
   input  logic    clk,
   input  logic    reset,
   exMemIf.dst     fromEx,
   input  logic    haltIn,
   input  logic    errIn,
   output logic    wbEn,
   output regIdx_t wbReg,
   output word_t   wbData,
   output logic    halted,
   output logic    err
);

   word_t               ram [DMEM_WORDS];
   logic  [DMEM_AW-1:0] addr;
   word_t               loadData;

   // Word address wraps to the RAM size
   assign addr     = fromEx.result[DMEM_AW-1:0];
   assign loadData = ram[addr];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            ram[i] <= '0;
         end
      end else if (fromEx.valid && fromEx.memWrite) begin
         ram[addr] <= fromEx.storeData;
      end
   end

   // Halt and error stay set until reset
   always_ff @(posedge clk) begin
      if (reset) begin
         wbEn   <= 1'b0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         wbEn   <= fromEx.valid && fromEx.regWrite;
         halted <= halted || haltIn;
         err    <= err || errIn;
      end
   end

   always_ff @(posedge clk) begin
      wbReg  <= fromEx.dest;
      wbData <= fromEx.memRead ? loadData : fromEx.result;
   end

endmodule

// File: source/pipeIfs.sv
`timescale 1ns/1ps

// One decoded instruction on its way into execute
interface decExIf import procPkg::*; ();

   logic    valid;
   opcode_t opcode;
   aluOp_t  aluOp;
   word_t   rsData;
   word_t   rtData;
   word_t   immediate;
   word_t   pcPlusOne;
   regIdx_t dest;

   modport src (output valid, opcode, aluOp, rsData, rtData, immediate, pcPlusOne, dest);
   modport dst (input valid, opcode, aluOp, rsData, rtData, immediate, pcPlusOne, dest);

endinterface

// ALU result and memory controls on their way into the memory stage
interface exMemIf import procPkg::*; ();

   logic    valid;
   word_t   result;
   word_t   storeData;
   regIdx_t dest;
   logic    regWrite;
   logic    memRead;
   logic    memWrite;

   modport src (output valid, result, storeData, dest, regWrite, memRead, memWrite);
   modport dst (input valid, result, storeData, dest, regWrite, memRead, memWrite);

endinterface

// File: source/proc.sv
`timescale 1ns/1ps

module proc import procPkg::*; (
   input  logic    clk,
   input  logic    reset,
   output logic    err,
   output logic    halted,
   output logic    wbValid,
   output regIdx_t wbReg,
   output word_t   wbData
);

   word_t   instrFd;
   word_t   pcPlusOneFd;
   logic    validFd;
   logic    stall;
   logic    stopFetch;
   logic    redirect;
   word_t   target;
   regIdx_t exDest;
   logic    exWrites;
   logic    haltEm;
   logic    errEm;

   decExIf decEx ();
   exMemIf exMem ();

   fetch u_fetch (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),
      .stopFetch (stopFetch),
      .redirect  (redirect),
      .target    (target),
      .instr     (instrFd),
      .pcPlusOne (pcPlusOneFd),
      .valid     (validFd)
   );

   // Write-back drives the observation port and the register file directly
   decode u_decode (
      .clk       (clk),
      .reset     (reset),
      .instr     (instrFd),
      .pcPlusOne (pcPlusOneFd),
      .inValid   (validFd),
      .flush     (redirect),
      .wbEn      (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .exDest    (exDest),
      .exWrites  (exWrites),
      .stall     (stall),
      .stopFetch (stopFetch),
      .toEx      (decEx.src)
   );

   execute u_execute (
      .clk      (clk),
      .reset    (reset),
      .fromDec  (decEx.dst),
      .toMem    (exMem.src),
      .redirect (redirect),
      .target   (target),
      .exDest   (exDest),
      .exWrites (exWrites),
      .haltOut  (haltEm),
      .errOut   (errEm)
   );

   memoryStage u_memoryStage (
      .clk    (clk),
      .reset  (reset),
      .fromEx (exMem.dst),
      .haltIn (haltEm),
      .errIn  (errEm),
      .wbEn   (wbValid),
      .wbReg  (wbReg),
      .wbData (wbData),
      .halted (halted),
      .err    (err)
   );

endmodule

// File: source/procPkg.sv
package procPkg;

   // Datapath and storage sizes
   localparam int WORD_W     = 16;
   localparam int REG_IDX_W  = 3;
   localparam int REG_COUNT  = 2 ** REG_IDX_W;
   localparam int IMEM_WORDS = 256;
   localparam int DMEM_WORDS = 256;
   localparam int IMEM_AW    = $clog2(IMEM_WORDS);
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] regIdx_t;

   localparam word_t RESET_PC = '0;

   // Instruction field positions
   localparam int OPC_MSB    = 15;
   localparam int OPC_LSB    = 11;
   localparam int RS_MSB     = 10;
   localparam int RS_LSB     = 8;
   localparam int RT_MSB     = 7;
   localparam int RT_LSB     = 5;
   localparam int RD_MSB     = 4;
   localparam int RD_LSB     = 2;
   localparam int IMM5_MSB   = 4;
   localparam int DISP8_MSB  = 7;
   localparam int DISP11_MSB = 10;

   // Opcodes in instruction bits 15 to 11
   // Any code not listed here is illegal
   typedef enum logic [4:0] {
      OP_NOP  = 5'h00,
      OP_HALT = 5'h01,
      OP_ADDI = 5'h02,
      OP_ADD  = 5'h03,
      OP_SUB  = 5'h04,
      OP_AND  = 5'h05,
      OP_XOR  = 5'h06,
      OP_LD   = 5'h07,
      OP_ST   = 5'h08,
      OP_BEQZ = 5'h09,
      OP_BNEZ = 5'h0A,
      OP_J    = 5'h0B
   } opcode_t;

   // ZEROTEST leaves the rs zero flag in bit 0
   typedef enum logic [2:0] {
      ALU_ADD      = 3'd0,
      ALU_SUB      = 3'd1,
      ALU_AND      = 3'd2,
      ALU_XOR      = 3'd3,
      ALU_PASSB    = 3'd4,
      ALU_ZEROTEST = 3'd5
   } aluOp_t;

endpackage

// File: verif/procTb.sv
`timescale 1ns/1ps

module procTb import procPkg::*; ();

   localparam int NUM_EXPECTED   = 9;
   // About four times the longest run of the test program
   localparam int TIMEOUT_CYCLES = 400;
   localparam int SETTLE_CYCLES  = 8;

   logic    clk;
   logic    reset;
   logic    err;
   logic    halted;
   logic    wbValid;
   regIdx_t wbReg;
   word_t   wbData;

   regIdx_t expRegTable [NUM_EXPECTED];
   word_t   expDataTable [NUM_EXPECTED];
   regIdx_t expReg;
   word_t   expData;
   int      wbIndex = 0;
   int      cycleCount = 0;

   proc u_proc (
      .clk     (clk),
      .reset   (reset),
      .err     (err),
      .halted  (halted),
      .wbValid (wbValid),
      .wbReg   (wbReg),
      .wbData  (wbData)
   );

   bind proc procProps u_procProps (
      .clk        (clk),
      .reset      (reset),
      .err        (err),
      .halted     (halted),
      .wbValid    (wbValid),
      .redirect   (redirect),
      .fetchValid (validFd)
   );

   task automatic stopWithFailure(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic setExpected(input int idx, input regIdx_t r, input word_t d);
      expRegTable[idx]  = r;
      expDataTable[idx] = d;
   endtask

   // Write-back order worked out by hand from program.hex
   initial begin
      setExpected(0, 3'd1, 16'h0005);
      setExpected(1, 3'd2, 16'hFFFD);
      setExpected(2, 3'd3, 16'h0002);
      setExpected(3, 3'd4, 16'h0003);
      setExpected(4, 3'd5, 16'h0001);
      setExpected(5, 3'd6, 16'hFFF8);
      // Load back from address 9, then from 0xFFF8 wrapped to 0xF8
      setExpected(6, 3'd7, 16'hFFF8);
      setExpected(7, 3'd3, 16'h0005);
      // Only the branch targets contribute after this
      setExpected(8, 3'd7, 16'h0008);
   end

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   assign expReg  = expRegTable[wbIndex];
   assign expData = expDataTable[wbIndex];

   always @(posedge clk) begin
      if (reset) begin
         wbIndex <= 0;
      end else if (wbValid) begin
         wbIndex <= wbIndex + 1;
      end
   end

   // Observation outputs low during and right after reset
   assert property (@(posedge clk) reset |=> (!wbValid && !halted && !err))
      else stopWithFailure("wbValid, halted or err not low during or after reset");

   assert property (@(posedge clk) disable iff (reset) wbValid |-> (wbIndex < NUM_EXPECTED))
      else stopWithFailure("more write-backs than the expected table holds");

   assert property (@(posedge clk) disable iff (reset)
                    (wbValid && wbIndex < NUM_EXPECTED) |-> (wbReg == expReg))
      else stopWithFailure($sformatf("[ERROR] wbReg expected 0x%h actual 0x%h",
                                     $sampled(expReg), $sampled(wbReg)));

   assert property (@(posedge clk) disable iff (reset)
                    (wbValid && wbIndex < NUM_EXPECTED) |-> (wbData == expData))
      else stopWithFailure($sformatf("[ERROR] wbData expected 0x%h actual 0x%h",
                                     $sampled(expData), $sampled(wbData)));

   // Bound invariant failures show up half a cycle after the edge that flagged them
   always @(negedge clk) begin
      if (u_proc.u_procProps.violation) begin
         stopWithFailure("a pipeline invariant assertion failed");
      end
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         stopWithFailure("timeout, the processor did not halt within the cycle limit");
      end
   end

   initial begin
      reset = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      while (halted !== 1'b1) begin
         @(posedge clk);
      end
      // Give a stray write-back time to show up
      repeat (SETTLE_CYCLES) @(posedge clk);
      if (wbIndex == NUM_EXPECTED) begin
         $display("Regression passed");
         $finish;
      end else begin
         stopWithFailure($sformatf("halted after %0d of %0d expected write-backs",
                                   wbIndex, NUM_EXPECTED));
      end
   end

endmodule

// File: verif/proc_props.sv
`timescale 1ns/1ps

module procProps (
   input logic clk,
   input logic reset,
   input logic err,
   input logic halted,
   input logic wbValid,
   input logic redirect,
   input logic fetchValid
);

   logic errRaised       = 1'b0;
   logic haltDropped     = 1'b0;
   logic lateWriteBack   = 1'b0;
   logic fetchNotFlushed = 1'b0;
   logic violation;

   assign violation = errRaised | haltDropped | lateWriteBack | fetchNotFlushed;

   // The test program holds no reachable illegal opcode
   assert property (@(posedge clk) disable iff (reset) !err)
      else begin
         $error("err went high");
         errRaised = 1'b1;
      end

   // Sticky until the next reset
   assert property (@(posedge clk) disable iff (reset) halted |=> halted)
      else begin
         $error("halted fell without reset");
         haltDropped = 1'b1;
      end

   assert property (@(posedge clk) disable iff (reset) halted |-> !wbValid)
      else begin
         $error("write-back seen after halt");
         lateWriteBack = 1'b1;
      end

   // Redirect clears the fetch-to-decode register
   assert property (@(posedge clk) disable iff (reset) redirect |=> !fetchValid)
      else begin
         $error("fetch still valid after redirect");
         fetchNotFlushed = 1'b1;
      end

endmodule

// File: verif/program.hex
// One 16-bit instruction word per line, in hex, starting at address 0
// Opcode in bits 15:11, rs 10:8, rt 7:5, rd 4:2, imm5 4:0, disp8 7:0, disp11 10:0
1025  // 00 ADDI r1, r0, 5
105D  // 01 ADDI r2, r0, -3
194C  // 02 ADD  r3, r1, r2
2170  // 03 SUB  r4, r1, r3
2994  // 04 AND  r5, r1, r4
3238  // 05 XOR  r6, r2, r1
41C4  // 06 ST   r6, 4(r1)
38E9  // 07 LD   r7, 9(r0)
4620  // 08 ST   r1, 0(r6)
3A7B  // 09 LD   r3, -5(r2)
4D02  // 10 BEQZ r5, +2 (not taken)
5502  // 11 BNEZ r5, +2 (taken)
1087  // 12 ADDI r4, r0, 7 (skipped)
F800  // 13 illegal opcode (skipped)
4802  // 14 BEQZ r0, +2 (taken)
10E1  // 15 ADDI r7, r0, 1 (skipped)
0800  // 16 HALT (skipped)
5802  // 17 J +2
10C2  // 18 ADDI r6, r0, 2 (skipped)
10C3  // 19 ADDI r6, r0, 3 (skipped)
1B9C  // 20 ADD  r7, r3, r4
0800  // 21 HALT
1029  // 22 ADDI r1, r0, 9 (never runs)
